//--- hdl/rs_pkg.sv
package rs_pkg;

    localparam int XLEN       = 32;
    localparam int ISSUE_WAYS = 3;
    localparam int RS_DEPTH   = 16;
    localparam int PRF_SIZE   = 64;
    localparam int ROB_SIZE   = 16;
    localparam int OFFSET_LEN = 16;

    localparam int TAG_W      = $clog2(PRF_SIZE);
    localparam int ROB_W      = $clog2(ROB_SIZE);

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [TAG_W-1:0]             prf_tag_t;
    typedef logic [ROB_W-1:0]             rob_idx_t;
    typedef logic [OFFSET_LEN-1:0]        offset_t;
    typedef logic [$clog2(RS_DEPTH+1)-1:0] free_count_t;
    typedef logic [$clog2(ISSUE_WAYS+1)-1:0] way_count_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_e;

    // low bits of value hold the waiting tag while valid is 0
    typedef struct packed {
        word_t value;
        logic  valid;
    } operand_t;

    typedef struct packed {
        logic     valid;
        prf_tag_t tag;
        word_t    data;
    } cdb_lane_t;

    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        operand_t opa;
        operand_t opb;
        prf_tag_t dest_tag;
        rob_idx_t rob_idx;
        offset_t  offset;
        logic     rd_mem;
        logic     wr_mem;
    } rs_inst_t;

    typedef struct packed {
        alu_op_e  op;
        word_t    opa;
        word_t    opb;
        prf_tag_t dest_tag;
        rob_idx_t rob_idx;
        offset_t  offset;
        logic     rd_mem;
        logic     wr_mem;
    } issue_inst_t;

endpackage

//--- hdl/way_select.sv
`timescale 1ns/1ps

module way_select
    import rs_pkg::*;
(
    input  logic [RS_DEPTH-1:0] req,
    output logic [RS_DEPTH-1:0] grant,
    output way_count_t          rank [RS_DEPTH]
);

    // lowest index wins, up to ISSUE_WAYS grants per cycle
    always_comb begin
        way_count_t count;
        count = '0;
        grant = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            rank[i] = '0;
            if (req[i] && (count < way_count_t'(ISSUE_WAYS))) begin
                grant[i] = 1'b1;
                // position among the grants so far
                rank[i]  = count;
                count    = count + way_count_t'(1);
            end
        end
    end

endmodule

//--- hdl/operand_wakeup.sv
`timescale 1ns/1ps

module operand_wakeup
    import rs_pkg::*;
(
    input  operand_t  operand_in,
    input  cdb_lane_t cdb [ISSUE_WAYS],
    output operand_t  operand_out
);

    always_comb begin
        operand_out = operand_in;
        if (!operand_in.valid) begin
            // tag sits in the low bits while waiting
            for (int k = 0; k < ISSUE_WAYS; k++) begin
                if (cdb[k].valid && (cdb[k].tag == operand_in.value[TAG_W-1:0])) begin
                    operand_out.value = cdb[k].data;
                    operand_out.valid = 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/rs_entry.sv
`timescale 1ns/1ps

module rs_entry
    import rs_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        load,
    input  rs_inst_t    load_inst,
    input  cdb_lane_t   cdb [ISSUE_WAYS],
    input  logic        issue_grant,
    output logic        busy,
    output logic        ready,
    output issue_inst_t payload
);

    alu_op_e  op_q;
    operand_t opa_q;
    operand_t opb_q;
    operand_t opa_woken;
    operand_t opb_woken;
    prf_tag_t dest_tag_q;
    rob_idx_t rob_idx_q;
    offset_t  offset_q;
    logic     rd_mem_q;
    logic     wr_mem_q;

    operand_wakeup u_wake_opa (
        .operand_in  (opa_q),
        .cdb         (cdb),
        .operand_out (opa_woken)
    );

    operand_wakeup u_wake_opb (
        .operand_in  (opb_q),
        .cdb         (cdb),
        .operand_out (opb_woken)
    );

    // a new load wins over the issue that frees the slot
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
        end else if (issue_grant) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            op_q       <= load_inst.op;
            opa_q      <= load_inst.opa;
            opb_q      <= load_inst.opb;
            dest_tag_q <= load_inst.dest_tag;
            rob_idx_q  <= load_inst.rob_idx;
            offset_q   <= load_inst.offset;
            rd_mem_q   <= load_inst.rd_mem;
            wr_mem_q   <= load_inst.wr_mem;
        end else if (busy) begin
            // keep snooping the cdb while waiting
            opa_q <= opa_woken;
            opb_q <= opb_woken;
        end
    end

    assign ready = busy && opa_q.valid && opb_q.valid;

    always_comb begin
        payload.op       = op_q;
        payload.opa      = opa_q.value;
        payload.opb      = opb_q.value;
        payload.dest_tag = dest_tag_q;
        payload.rob_idx  = rob_idx_q;
        payload.offset   = offset_q;
        payload.rd_mem   = rd_mem_q;
        payload.wr_mem   = wr_mem_q;
    end

endmodule

//--- hdl/rs_dispatch.sv
`timescale 1ns/1ps

module rs_dispatch
    import rs_pkg::*;
(
    input  rs_inst_t            dispatch [ISSUE_WAYS],
    input  cdb_lane_t           cdb [ISSUE_WAYS],
    input  logic [RS_DEPTH-1:0] grant,
    input  way_count_t          rank [RS_DEPTH],
    output logic [RS_DEPTH-1:0] load,
    output rs_inst_t            load_inst [RS_DEPTH]
);

    operand_t opa_cap [ISSUE_WAYS];
    operand_t opb_cap [ISSUE_WAYS];
    rs_inst_t lanes   [ISSUE_WAYS];

    // same-cycle capture of broadcasts on each incoming lane
    for (genvar k = 0; k < ISSUE_WAYS; k++) begin : g_lane
        operand_wakeup u_cap_opa (
            .operand_in  (dispatch[k].opa),
            .cdb         (cdb),
            .operand_out (opa_cap[k])
        );

        operand_wakeup u_cap_opb (
            .operand_in  (dispatch[k].opb),
            .cdb         (cdb),
            .operand_out (opb_cap[k])
        );

        always_comb begin
            lanes[k]     = dispatch[k];
            lanes[k].opa = opa_cap[k];
            lanes[k].opb = opb_cap[k];
        end
    end

    // granted entry of rank r takes lane r
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            load_inst[i] = lanes[0];
            for (int k = 1; k < ISSUE_WAYS; k++) begin
                if (rank[i] == way_count_t'(k)) begin
                    load_inst[i] = lanes[k];
                end
            end
            // lanes are contiguous, so an empty lane leaves the slot free
            load[i] = grant[i] && load_inst[i].valid;
        end
    end

endmodule

//--- hdl/rs_issue.sv
`timescale 1ns/1ps

module rs_issue
    import rs_pkg::*;
(
    input  logic [RS_DEPTH-1:0]   grant,
    input  way_count_t            rank [RS_DEPTH],
    input  issue_inst_t           payload [RS_DEPTH],
    output logic [ISSUE_WAYS-1:0] issue_valid,
    output issue_inst_t           issue [ISSUE_WAYS]
);

    // pack granted entries onto lanes by rank
    always_comb begin
        issue_valid = '0;
        for (int k = 0; k < ISSUE_WAYS; k++) begin
            issue[k] = '0;
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            for (int k = 0; k < ISSUE_WAYS; k++) begin
                if (grant[i] && (rank[i] == way_count_t'(k))) begin
                    issue_valid[k] = 1'b1;
                    issue[k]       = payload[i];
                end
            end
        end
    end

endmodule

//--- hdl/reservation_station.sv
`timescale 1ns/1ps

module reservation_station
    import rs_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  rs_inst_t              dispatch [ISSUE_WAYS],
    input  cdb_lane_t             cdb [ISSUE_WAYS],
    output logic [ISSUE_WAYS-1:0] issue_valid,
    output issue_inst_t           issue [ISSUE_WAYS],
    output free_count_t           num_free
);

    logic [RS_DEPTH-1:0] busy;
    logic [RS_DEPTH-1:0] ready;
    logic [RS_DEPTH-1:0] issue_grant;
    logic [RS_DEPTH-1:0] disp_grant;
    logic [RS_DEPTH-1:0] load;
    way_count_t          issue_rank [RS_DEPTH];
    way_count_t          disp_rank  [RS_DEPTH];
    rs_inst_t            load_inst  [RS_DEPTH];
    issue_inst_t         payload    [RS_DEPTH];
    way_count_t          n_dispatched;
    way_count_t          n_issued;

    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_entry
        rs_entry u_entry (
            .clock       (clock),
            .reset       (reset),
            .load        (load[i]),
            .load_inst   (load_inst[i]),
            .cdb         (cdb),
            .issue_grant (issue_grant[i]),
            .busy        (busy[i]),
            .ready       (ready[i]),
            .payload     (payload[i])
        );
    end

    way_select u_issue_select (
        .req   (ready),
        .grant (issue_grant),
        .rank  (issue_rank)
    );

    // an entry leaving this cycle can be refilled at the same edge
    way_select u_dispatch_select (
        .req   (~busy | issue_grant),
        .grant (disp_grant),
        .rank  (disp_rank)
    );

    rs_dispatch u_dispatch (
        .dispatch  (dispatch),
        .cdb       (cdb),
        .grant     (disp_grant),
        .rank      (disp_rank),
        .load      (load),
        .load_inst (load_inst)
    );

    rs_issue u_issue (
        .grant       (issue_grant),
        .rank        (issue_rank),
        .payload     (payload),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    always_comb begin
        n_dispatched = '0;
        n_issued     = '0;
        for (int k = 0; k < ISSUE_WAYS; k++) begin
            n_dispatched = n_dispatched + way_count_t'(dispatch[k].valid);
            n_issued     = n_issued + way_count_t'(issue_valid[k]);
        end
    end

    // free count seen by the dispatch stage, one cycle behind
    always_ff @(posedge clock) begin
        if (reset) begin
            num_free <= free_count_t'(RS_DEPTH);
        end else begin
            num_free <= num_free - free_count_t'(n_dispatched) + free_count_t'(n_issued);
        end
    end

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clock
);

    // 20 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #10;
            clock = ~clock;
        end
    end

endmodule

//--- sim/rs_chk.sv
`timescale 1ns/1ps

module rs_chk
    import rs_pkg::*;
(
    input logic                  clock,
    input logic                  reset,
    input logic [ISSUE_WAYS-1:0] issue_valid,
    input free_count_t           num_free
);

    localparam logic [ISSUE_WAYS-1:0] LANE_ONE = 1;

    // no gap above the lowest idle lane
    a_lanes_packed: assert property (@(posedge clock) disable iff (reset)
        (issue_valid & (issue_valid + LANE_ONE)) == '0)
        else $error("issue_valid lanes are not contiguous from lane 0");

    a_free_bound: assert property (@(posedge clock) disable iff (reset)
        num_free <= free_count_t'(RS_DEPTH))
        else $error("num_free exceeds the station depth");

    a_idle_after_reset: assert property (@(posedge clock)
        reset |=> (issue_valid == '0))
        else $error("issue_valid set in the cycle after reset");

endmodule

bind reservation_station rs_chk u_rs_chk (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .num_free    (num_free)
);

//--- sim/rs_tb.sv
`timescale 1ns/1ps

module rs_tb
    import rs_pkg::*;
();

    typedef logic [ISSUE_WAYS-1:0] lane_vec_t;

    logic        clock;
    logic        reset;
    rs_inst_t    dispatch [ISSUE_WAYS];
    cdb_lane_t   cdb [ISSUE_WAYS];
    lane_vec_t   issue_valid;
    issue_inst_t issue [ISSUE_WAYS];
    free_count_t num_free;
    int          errors;
    int          timeouts;
    logic [31:0] rng_state;
    rs_inst_t    insts [RS_DEPTH];

    tb_clock u_clock (.clock(clock));

    reservation_station i_reservation_station (
        .clock       (clock),
        .reset       (reset),
        .dispatch    (dispatch),
        .cdb         (cdb),
        .issue_valid (issue_valid),
        .issue       (issue),
        .num_free    (num_free)
    );

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic operand_t value_op(input word_t v);
        return '{value: v, valid: 1'b1};
    endfunction

    // waiting operand carries its tag in the low bits
    function automatic operand_t tag_op(input prf_tag_t t);
        return '{value: word_t'(t), valid: 1'b0};
    endfunction

    function automatic rs_inst_t make_inst(input operand_t a, input operand_t b);
        rs_inst_t    inst;
        logic [31:0] r;
        r = next_random();
        inst.valid    = 1'b1;
        inst.op       = alu_op_e'({1'b0, r[2:0]});
        inst.opa      = a;
        inst.opb      = b;
        inst.dest_tag = r[13:8];
        inst.rob_idx  = r[23:20];
        inst.offset   = r[31:16];
        inst.rd_mem   = r[4];
        inst.wr_mem   = r[5];
        return inst;
    endfunction

    function automatic issue_inst_t expected_issue(input rs_inst_t i, input word_t a,
                                                   input word_t b);
        return '{i.op, a, b, i.dest_tag, i.rob_idx, i.offset, i.rd_mem, i.wr_mem};
    endfunction

    task automatic check_issue(input issue_inst_t got, input issue_inst_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: issue payload %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_count(input free_count_t got, input free_count_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: num_free %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_valid(input lane_vec_t got, input lane_vec_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: issue_valid %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic clear_inputs();
        for (int k = 0; k < ISSUE_WAYS; k++) begin
            dispatch[k] = '0;
            cdb[k]      = '0;
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    // samples at falling edges until something issues
    task automatic wait_issue(input int limit, output bit ok);
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (issue_valid == '0 && n < limit);
        ok = (issue_valid != '0);
        if (!ok) begin
            timeouts++;
            $display("timeout: nothing issued within %0d cycles at %0t", limit, $time);
        end
    endtask

    task automatic test_reset();
        @(negedge clock);
        check_count(num_free, free_count_t'(RS_DEPTH));
        check_valid(issue_valid, '0);
    endtask

    task automatic test_three_ready();
        next_cycle();
        for (int k = 0; k < ISSUE_WAYS; k++) begin
            insts[k]    = make_inst(value_op(next_random()), value_op(next_random()));
            dispatch[k] = insts[k];
        end
        next_cycle();
        clear_inputs();
        @(negedge clock);
        check_valid(issue_valid, '1);
        for (int k = 0; k < ISSUE_WAYS; k++) begin
            check_issue(issue[k], expected_issue(insts[k], insts[k].opa.value,
                                                 insts[k].opb.value));
        end
        check_count(num_free, free_count_t'(RS_DEPTH - ISSUE_WAYS));
        next_cycle();
        @(negedge clock);
        check_count(num_free, free_count_t'(RS_DEPTH));
        check_valid(issue_valid, '0);
    endtask

    task automatic test_wait_tag();
        word_t data;
        bit    ok;
        next_cycle();
        insts[0]    = make_inst(value_op(next_random()), tag_op(6'd5));
        dispatch[0] = insts[0];
        next_cycle();
        clear_inputs();
        repeat (3) begin
            @(negedge clock);
            check_valid(issue_valid, '0);
        end
        next_cycle();
        data = next_random();
        cdb[1] = '{valid: 1'b1, tag: 6'd5, data: data};
        next_cycle();
        clear_inputs();
        // woken operand issues in the very next cycle
        wait_issue(1, ok);
        if (ok) begin
            check_valid(issue_valid, lane_vec_t'(1));
            check_issue(issue[0], expected_issue(insts[0], insts[0].opa.value, data));
        end
    endtask

    task automatic test_same_cycle_capture();
        word_t data;
        next_cycle();
        data        = next_random();
        insts[0]    = make_inst(tag_op(6'd9), value_op(next_random()));
        dispatch[0] = insts[0];
        cdb[0]      = '{valid: 1'b1, tag: 6'd9, data: data};
        next_cycle();
        clear_inputs();
        @(negedge clock);
        check_valid(issue_valid, lane_vec_t'(1));
        check_issue(issue[0], expected_issue(insts[0], data, insts[0].opb.value));
    endtask

    task automatic test_fill_and_drain();
        word_t data;
        bit    ok;
        int    idx;
        int    n;
        next_cycle();
        for (int i = 0; i < RS_DEPTH; i += ISSUE_WAYS) begin
            clear_inputs();
            for (int k = 0; k < ISSUE_WAYS; k++) begin
                if (i + k < RS_DEPTH) begin
                    insts[i + k] = make_inst(tag_op(6'd20), value_op(next_random()));
                    dispatch[k]  = insts[i + k];
                end
            end
            next_cycle();
        end
        clear_inputs();
        @(negedge clock);
        check_count(num_free, '0);
        check_valid(issue_valid, '0);
        next_cycle();
        data   = next_random();
        cdb[2] = '{valid: 1'b1, tag: 6'd20, data: data};
        next_cycle();
        clear_inputs();
        // oldest entries first, three per cycle back to back
        idx = 0;
        while (idx < RS_DEPTH) begin
            wait_issue(1, ok);
            if (!ok) begin
                break;
            end
            n = (RS_DEPTH - idx < ISSUE_WAYS) ? RS_DEPTH - idx : ISSUE_WAYS;
            check_valid(issue_valid, lane_vec_t'((1 << n) - 1));
            for (int k = 0; k < n; k++) begin
                check_issue(issue[k], expected_issue(insts[idx], data,
                                                     insts[idx].opb.value));
                idx++;
            end
        end
        next_cycle();
        @(negedge clock);
        check_count(num_free, free_count_t'(RS_DEPTH));
    endtask

    initial begin
        errors    = 0;
        timeouts  = 0;
        rng_state = 32'h6492736c;
        reset     = 1'b1;
        clear_inputs();
        repeat (5) @(posedge clock);
        #2;
        reset = 1'b0;
        test_reset();
        test_three_ready();
        test_wait_tag();
        test_same_cycle_capture();
        test_fill_and_drain();
        $display("errors: %0d value, %0d timeout", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // last resort if a test stalls
    initial begin
        #200us;
        $display("simulation stopped by watchdog after 200 us");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- flist.f
hdl/rs_pkg.sv
hdl/way_select.sv
hdl/operand_wakeup.sv
hdl/rs_entry.sv
hdl/rs_dispatch.sv
hdl/rs_issue.sv
hdl/reservation_station.sv
sim/tb_clock.sv
sim/rs_chk.sv
sim/rs_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the reservation station testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f flist.f --top-module rs_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vrs_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0
